/* key_params_pkg.sv */
// Key input global constants

package key_params_pkg;

	// ********************
	// Key vector
	// ********************

	// Number of key lines from the pins
	localparam int N_KEYS = 8;

	// One bit per key, bit index is the key number
	typedef logic [N_KEYS-1:0] key_vec_t;

	// ********************
	// Filter defaults
	// ********************

	// Saturating counter width per key
	// Top bit of the count is the filtered level
	localparam int DEF_CNT_WIDTH = 3;

	// Clocks between two sampling ticks
	localparam int DEF_TICK_DIV = 16;

endpackage

/* key_event_pkg.sv */
// Key event type definitions

package key_event_pkg;

	// Key count sets the code width
	import key_params_pkg::*;

	// ********************
	// Event code
	// ********************

	// Bits needed to name one key
	localparam int KEY_CODE_WIDTH = $clog2(N_KEYS);

	// Index of the key that caused an event
	typedef logic [KEY_CODE_WIDTH-1:0] key_code_t;

	// ********************
	// Event kind
	// ********************

	// New level of the key that changed
	typedef logic key_kind_t;

	// Key went high
	localparam key_kind_t KIND_PRESS = 1'b1;
	// Key went low
	localparam key_kind_t KIND_RELEASE = 1'b0;

endpackage

/* key_sampler.sv */
// Key input sampler

module key_sampler
	import key_params_pkg::*;
#(
	// Clocks per sampling tick, at least 2
	parameter int TICK_DIV = DEF_TICK_DIV
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  key_vec_t keys_raw,
	output key_vec_t keys_sync,
	output logic     tick
);

	// Divider counter width
	localparam int DIV_WIDTH = $clog2(TICK_DIV);
	// Last divider state, tick fires here
	localparam logic [DIV_WIDTH-1:0] DIV_LAST = DIV_WIDTH'(TICK_DIV - 1);

	// First synchronizer stage, may go metastable
	key_vec_t keys_meta;

	// Free-running tick divider
	logic [DIV_WIDTH-1:0] div_cnt;

	// ********************
	// Synchronizer
	// ********************

	// Pins are asynchronous to clk
	// Two flops give keys_sync two edges of latency
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			keys_meta <= '0;
			keys_sync <= '0;
		end
		else
		begin
			keys_meta <= keys_raw;
			keys_sync <= keys_meta;
		end
	end

	// ********************
	// Tick divider
	// ********************

	// Counts 0 to TICK_DIV-1 and wraps
	// Runs from reset, not gated by enable
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			div_cnt <= '0;
		else if (div_cnt == DIV_LAST)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// One-cycle pulse on the last divider state
	// First tick comes TICK_DIV cycles after reset release
	assign tick = (div_cnt == DIV_LAST);

endmodule

/* updown_counter.sv */
// Saturating up/down counter

module updown_counter
#(
	// Count width, at least 2
	parameter int CNT_WIDTH = 3
)
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 enable,
	input  logic                 up,
	input  logic                 down,
	output logic [CNT_WIDTH-1:0] value
);

	// Upper limit of the unsigned count
	localparam logic [CNT_WIDTH-1:0] CNT_MAX = '1;

	// Limit flags
	logic at_max;
	logic at_min;

	// Step requests that survive the limits
	logic step_up;
	logic step_down;

	assign at_max = (value == CNT_MAX);
	assign at_min = (value == '0);

	// Up and down together cancel out
	// No wrap past either limit
	assign step_up   = enable & up & ~down & ~at_max;
	assign step_down = enable & down & ~up & ~at_min;

	// ********************
	// Count register
	// ********************

	// Reset starts the count at zero
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			value <= '0;
		else if (step_up)
			value <= value + 1'b1;
		else if (step_down)
			value <= value - 1'b1;
	end

endmodule

/* key_debouncer.sv */
// Key debounce filter

module key_debouncer
	import key_params_pkg::*;
#(
	// Filter counter width, at least 2
	parameter int CNT_WIDTH = DEF_CNT_WIDTH
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     enable,
	input  logic     tick,
	input  key_vec_t keys_sync,
	output key_vec_t keys_debounced
);

	// Per-key filter counts
	logic [CNT_WIDTH-1:0] cnt_value [N_KEYS];

	// Per-key step strobes
	key_vec_t cnt_up;
	key_vec_t cnt_down;

	// ********************
	// Filter per key
	// ********************

	for (genvar i = 0; i < N_KEYS; i++)
	begin : g_key
		// High sample moves toward pressed, low toward released
		assign cnt_up[i]   = tick & keys_sync[i];
		assign cnt_down[i] = tick & ~keys_sync[i];

		// Counter freezes while enable is low
		updown_counter
		#(
			.CNT_WIDTH(CNT_WIDTH)
		)
		i_updown_counter
		(
			.clk(clk),
			.rst_n(rst_n),
			.enable(enable),
			.up(cnt_up[i]),
			.down(cnt_down[i]),
			.value(cnt_value[i])
		);

		// Top bit is the filtered level
		// Bypass passes the synchronized level straight through
		assign keys_debounced[i] = enable ? cnt_value[i][CNT_WIDTH-1] : keys_sync[i];
	end

endmodule

/* key_event_detect.sv */
// Key edge and event detector

module key_event_detect
	import key_params_pkg::*;
	import key_event_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  key_vec_t  keys_debounced,
	output key_vec_t  key_press,
	output key_vec_t  key_release,
	output logic      event_valid,
	output key_code_t event_code,
	output key_kind_t event_kind
);

	// Debounced levels one cycle back
	key_vec_t keys_prev;

	// Edge vectors against the previous levels
	key_vec_t keys_rise;
	key_vec_t keys_fall;
	key_vec_t keys_changed;

	// Priority encoder result
	key_code_t sel_code;
	key_kind_t sel_kind;

	assign keys_rise    = keys_debounced & ~keys_prev;
	assign keys_fall    = ~keys_debounced & keys_prev;
	assign keys_changed = keys_rise | keys_fall;

	// ********************
	// Priority encoder
	// ********************

	// Walks from the top key down
	// Last hit wins, so the lowest changed index is kept
	always_comb
	begin
		sel_code = '0;
		sel_kind = KIND_RELEASE;
		for (int i = N_KEYS - 1; i >= 0; i--)
		begin
			if (keys_changed[i])
			begin
				sel_code = key_code_t'(i);
				sel_kind = keys_debounced[i] ? KIND_PRESS : KIND_RELEASE;
			end
		end
	end

	// ********************
	// Output registers
	// ********************

	// Every output lasts one cycle per change
	// Code and kind drop back to zero when nothing changed
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			keys_prev   <= '0;
			key_press   <= '0;
			key_release <= '0;
			event_valid <= 1'b0;
			event_code  <= '0;
			event_kind  <= KIND_RELEASE;
		end
		else
		begin
			keys_prev   <= keys_debounced;
			key_press   <= keys_rise;
			key_release <= keys_fall;
			event_valid <= |keys_changed;
			event_code  <= sel_code;
			event_kind  <= sel_kind;
		end
	end

endmodule

/* key_input_top.sv */
// Key input front end

module key_input_top
	import key_params_pkg::*;
	import key_event_pkg::*;
#(
	// Filter counter width
	parameter int CNT_WIDTH = DEF_CNT_WIDTH,
	// Clocks per sampling tick
	parameter int TICK_DIV  = DEF_TICK_DIV
)
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      enable,
	input  key_vec_t  keys_raw,
	output key_vec_t  keys_debounced,
	output key_vec_t  key_press,
	output key_vec_t  key_release,
	output logic      event_valid,
	output key_code_t event_code,
	output key_kind_t event_kind
);

	// Sampler to debouncer
	key_vec_t keys_sync;
	logic     tick;

	// ********************
	// Decode stage
	// ********************

	// Pin synchronizer and tick divider
	key_sampler
	#(
		.TICK_DIV(TICK_DIV)
	)
	i_key_sampler
	(
		.clk(clk),
		.rst_n(rst_n),
		.keys_raw(keys_raw),
		.keys_sync(keys_sync),
		.tick(tick)
	);

	// ********************
	// Execute stage
	// ********************

	// Saturating filter per key, bypass when disabled
	key_debouncer
	#(
		.CNT_WIDTH(CNT_WIDTH)
	)
	i_key_debouncer
	(
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.tick(tick),
		.keys_sync(keys_sync),
		.keys_debounced(keys_debounced)
	);

	// ********************
	// Result stage
	// ********************

	// Press and release pulses plus one encoded event
	key_event_detect i_key_event_detect
	(
		.clk(clk),
		.rst_n(rst_n),
		.keys_debounced(keys_debounced),
		.key_press(key_press),
		.key_release(key_release),
		.event_valid(event_valid),
		.event_code(event_code),
		.event_kind(event_kind)
	);

endmodule

/* key_input_model.svh */
// Key input reference model

`ifndef KEY_INPUT_MODEL_SVH
`define KEY_INPUT_MODEL_SVH

	// Saturation limit and the count where the top bit sets
	localparam int CNT_TOP  = (1 << TB_CNT_WIDTH) - 1;
	localparam int CNT_HALF = 1 << (TB_CNT_WIDTH - 1);

	// ********************
	// Model state
	// ********************

	// Two synchronizer stages and the tick divider
	key_vec_t  m_meta;
	key_vec_t  m_sync;
	int        m_div;
	// One filter count per key
	int        m_cnt [N_KEYS];
	// Debounced levels seen at the last edge
	key_vec_t  m_prev;
	// Predicted registered outputs
	key_vec_t  m_press;
	key_vec_t  m_release;
	logic      m_valid;
	key_code_t m_code;
	key_kind_t m_kind;

	// Filtered level when enabled and synchronized level when bypassed
	function automatic key_vec_t predict_debounced(input logic en);
		key_vec_t deb;
		for (int k = 0; k < N_KEYS; k++)
			deb[k] = en ? (m_cnt[k] >= CNT_HALF) : m_sync[k];
		return deb;
	endfunction

	// Scan upward so the first changed key wins
	function automatic key_code_t lowest_changed(input key_vec_t changed);
		key_code_t code;
		bit        found;
		code = '0;
		found = 1'b0;
		for (int k = 0; k < N_KEYS; k++)
		begin
			if (changed[k] && !found)
			begin
				code = key_code_t'(k);
				found = 1'b1;
			end
		end
		return code;
	endfunction

	task automatic reset_model();
		m_meta = '0;
		m_sync = '0;
		m_div = 0;
		for (int k = 0; k < N_KEYS; k++)
			m_cnt[k] = 0;
		m_prev = '0;
		m_press = '0;
		m_release = '0;
		m_valid = 1'b0;
		m_code = '0;
		m_kind = 1'b0;
	endtask

	// One clock edge with every update using the values from before the edge
	task automatic step_model();
		key_vec_t deb_now;
		key_vec_t changed;
		logic     tick_now;
		if (!rst_n)
			reset_model();
		else
		begin
			tick_now = (m_div == TB_TICK_DIV - 1);
			deb_now = predict_debounced(enable);
			changed = deb_now ^ m_prev;
			m_press = deb_now & ~m_prev;
			m_release = m_prev & ~deb_now;
			m_valid = |changed;
			m_code = lowest_changed(changed);
			// Kind is the new level and zero when nothing moved
			m_kind = m_valid ? deb_now[m_code] : 1'b0;
			m_prev = deb_now;
			// Counters step on a tick only while enabled
			if (enable && tick_now)
			begin
				for (int k = 0; k < N_KEYS; k++)
				begin
					if (m_sync[k] && m_cnt[k] < CNT_TOP)
						m_cnt[k]++;
					else if (!m_sync[k] && m_cnt[k] > 0)
						m_cnt[k]--;
				end
			end
			m_sync = m_meta;
			m_meta = keys_raw;
			m_div = (m_div + 1) % TB_TICK_DIV;
		end
	endtask

`endif

/* tb_key_input.sv */
// Key input testbench

module tb_key_input
	import key_params_pkg::*;
	import key_event_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// ********************
	// Setup
	// ********************

	localparam int TB_TICK_DIV   = 4;
	localparam int TB_CNT_WIDTH  = 3;
	localparam int RESET_CYCLES  = 2;
	localparam int CLEAN_KEY     = 3;
	localparam int CLEAN_HOLD    = 40;
	localparam int GLITCH_KEY    = 5;
	localparam int GLITCH_MAX    = 10;
	localparam int GLITCH_GAP    = 40;
	localparam int BYPASS_CYCLES = 60;
	localparam int RANDOM_CYCLES = 3000;
	localparam int SETTLE_CYCLES = 20;
	// All phases back to back
	localparam int RUN_CYCLES = RESET_CYCLES + 2 * CLEAN_HOLD + SETTLE_CYCLES
		+ GLITCH_MAX * (GLITCH_MAX + 1) / 2 + GLITCH_MAX * GLITCH_GAP
		+ 2 * BYPASS_CYCLES + RANDOM_CYCLES + SETTLE_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

	// DUT ports
	logic      clk;
	logic      rst_n;
	logic      enable;
	key_vec_t  keys_raw;
	key_vec_t  keys_debounced;
	key_vec_t  key_press;
	key_vec_t  key_release;
	logic      event_valid;
	key_code_t event_code;
	key_kind_t event_kind;

	// Stimulus and bookkeeping
	integer    seed;
	int        hold_left [N_KEYS];
	int        mismatch_count = 0;
	int        other_errors = 0;
	int        cycle_count = 0;
	int        press_events = 0;
	int        release_events = 0;
	key_code_t press_code;
	key_code_t release_code;
	key_vec_t  deb_seen;
	key_vec_t  raw_hist1;
	key_vec_t  raw_hist2;
	logic      model_live = 1'b0;

	`include "key_input_model.svh"

	key_input_top
	#(
		.CNT_WIDTH(TB_CNT_WIDTH),
		.TICK_DIV(TB_TICK_DIV)
	)
	i_key_input_top
	(
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.keys_raw(keys_raw),
		.keys_debounced(keys_debounced),
		.key_press(key_press),
		.key_release(key_release),
		.event_valid(event_valid),
		.event_code(event_code),
		.event_kind(event_kind)
	);

	// 8 ns clock
	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// ********************
	// Helpers
	// ********************

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
		mismatch_count++;
	endtask

	// DUT against model at mid-cycle where everything has settled
	task automatic compare_outputs();
		key_vec_t exp_deb;
		exp_deb = predict_debounced(enable);
		if (keys_debounced !== exp_deb)
			report_mismatch("keys_debounced", 32'(exp_deb), 32'(keys_debounced));
		if (key_press !== m_press)
			report_mismatch("key_press", 32'(m_press), 32'(key_press));
		if (key_release !== m_release)
			report_mismatch("key_release", 32'(m_release), 32'(key_release));
		if (event_valid !== m_valid)
			report_mismatch("event_valid", 32'(m_valid), 32'(event_valid));
		if (event_code !== m_code)
			report_mismatch("event_code", 32'(m_code), 32'(event_code));
		if (event_kind !== m_kind)
			report_mismatch("event_kind", 32'(m_kind), 32'(event_kind));
	endtask

	// Reset values are all zero
	task automatic check_idle_outputs();
		if (keys_debounced !== '0)
			report_mismatch("keys_debounced", 0, 32'(keys_debounced));
		if (key_press !== '0 || key_release !== '0)
			report_mismatch("key_press|key_release", 0, 32'(key_press | key_release));
		if (event_valid !== 1'b0)
			report_mismatch("event_valid", 0, 32'(event_valid));
		if (event_code !== '0 || event_kind !== 1'b0)
			report_mismatch("event_code|event_kind", 0, 32'({event_code, event_kind}));
	endtask

	task automatic clear_event_counts();
		press_events = 0;
		release_events = 0;
		deb_seen = '0;
	endtask

	// Leaves the caller 1 ns past a rising edge
	task automatic wait_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic finish_run();
		$display("Mismatches: %0d, other errors: %0d", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	endtask

	// ********************
	// Model and monitor
	// ********************

	always @(posedge clk)
	begin
		step_model();
		model_live = 1'b1;
	end

	always @(negedge clk)
	begin
		if (model_live)
		begin
			compare_outputs();
			deb_seen = deb_seen | keys_debounced;
			if (event_valid === 1'b1 && event_kind === KIND_PRESS)
			begin
				press_events++;
				press_code = event_code;
			end
			else if (event_valid === 1'b1)
			begin
				release_events++;
				release_code = event_code;
			end
		end
	end

	// ********************
	// Stimulus
	// ********************

	initial
	begin
		seed = 32'hda52;
		rst_n = 1'b0;
		enable = 1'b1;
		keys_raw = '0;
		clear_event_counts();
		wait_cycles(RESET_CYCLES);
		check_idle_outputs();
		rst_n = 1'b1;
		wait_cycles(1);
		check_idle_outputs();

		// Clean press and release on one key
		clear_event_counts();
		keys_raw[CLEAN_KEY] = 1'b1;
		wait_cycles(CLEAN_HOLD);
		keys_raw[CLEAN_KEY] = 1'b0;
		wait_cycles(CLEAN_HOLD + SETTLE_CYCLES);
		if (press_events != 1 || release_events != 1)
		begin
			$display("Key %0d gave %0d press and %0d release events instead of one each",
				CLEAN_KEY, press_events, release_events);
			other_errors++;
		end
		if (press_code !== key_code_t'(CLEAN_KEY))
			report_mismatch("event_code", CLEAN_KEY, 32'(press_code));
		if (release_code !== key_code_t'(CLEAN_KEY))
			report_mismatch("event_code", CLEAN_KEY, 32'(release_code));

		// Pulses under four ticks with a long low gap after each
		clear_event_counts();
		for (int len = 1; len <= GLITCH_MAX; len++)
		begin
			keys_raw[GLITCH_KEY] = 1'b1;
			wait_cycles(len);
			keys_raw[GLITCH_KEY] = 1'b0;
			wait_cycles(GLITCH_GAP);
		end
		if (press_events + release_events != 0 || deb_seen != '0)
		begin
			$display("Short pulses on key %0d reached the debounced output", GLITCH_KEY);
			other_errors++;
		end

		// Bypass makes the output the raw level two edges late
		enable = 1'b0;
		raw_hist1 = keys_raw;
		raw_hist2 = keys_raw;
		for (int c = 0; c < BYPASS_CYCLES; c++)
		begin
			wait_cycles(1);
			if (keys_debounced !== raw_hist2)
				report_mismatch("keys_debounced", 32'(raw_hist2), 32'(keys_debounced));
			raw_hist2 = raw_hist1;
			keys_raw = key_vec_t'($random(seed));
			raw_hist1 = keys_raw;
		end
		// Filter picks up from the frozen counts
		enable = 1'b1;
		wait_cycles(BYPASS_CYCLES);

		// Random hold lengths per key and rare enable toggles
		for (int c = 0; c < RANDOM_CYCLES; c++)
		begin
			for (int k = 0; k < N_KEYS; k++)
			begin
				if (hold_left[k] == 0)
				begin
					keys_raw[k] = 1'($random(seed));
					hold_left[k] = {$random(seed)} % 31;
				end
				else
					hold_left[k]--;
			end
			if ({$random(seed)} % 250 == 0)
				enable = ~enable;
			wait_cycles(1);
		end
		enable = 1'b1;
		keys_raw = '0;
		wait_cycles(SETTLE_CYCLES);
		finish_run();
	end

	// Run limit
	initial
	begin
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		other_errors++;
		finish_run();
	end

endmodule

/* all.f */
+incdir+.
key_params_pkg.sv
key_event_pkg.sv
key_sampler.sv
updown_counter.sv
key_debouncer.sv
key_event_detect.sv
key_input_top.sv
tb_key_input.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the key input testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timescale 1ns/1ps -f all.f --top-module tb_key_input -o tb_key_input
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_key_input > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Verdict comes from the log
if grep -q "Something failed" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi

echo "Simulation passed"
exit 0
